//--- hw/timer_defines.svh
`ifndef TIMER_DEFINES_SVH
`define TIMER_DEFINES_SVH

// Core clock in Hz; an all-ones prescaler selects a one-second tick from it.
`define TIMER_CLK_FREQ 32'd50_000_000

// Word offsets on the 3-bit Wishbone address.
`define TIMER_REG_PRE  3'd0
`define TIMER_REG_ARE  3'd1
`define TIMER_REG_CTRL 3'd2
`define TIMER_REG_CMD  3'd3
`define TIMER_REG_CNT  3'd4
`define TIMER_REG_EVN  3'd5
`define TIMER_REG_STAT 3'd6

// CTRL holds enable in bit 0, count_up in bit 1 and irq_en in bit 2.
// CMD holds clr_cnt in bit 0, clr_evn in bit 1 and clr_irq in bit 2.

`define TIMER_PRE_RESET 32'hffff_ffff
`define TIMER_ARE_RESET 32'hffff_ffff

`endif

//--- hw/timer_pkg.sv
`default_nettype none

package timer_pkg;

	// Software-visible configuration, held by the bus decoder.
	typedef struct packed {
		logic [31:0] prescale;
		logic [31:0] reload;
		logic        enable;
		logic        count_up;
		logic        irq_en;
	} timer_cfg_t;

	// One-cycle command strobes, high during the ack cycle of the write.
	typedef struct packed {
		logic clr_cnt;
		logic clr_evn;
		logic clr_irq;
		logic pre_load; // Prescaler register was written.
	} timer_cmd_t;

	// Outputs of the count core.
	typedef struct packed {
		logic [31:0] count;
		logic [31:0] events;
		logic        evt;
	} timer_state_t;

endpackage

`default_nettype wire

//--- hw/timer_bus_decode.sv
`default_nettype none

`include "timer_defines.svh"

module timer_bus_decode (
	input  wire                     clk_i,
	input  wire                     rst_i,
	input  wire                     wb_cyc_i,
	input  wire                     wb_stb_i,
	input  wire                     wb_we_i,
	input  wire [2:0]               wb_adr_i,
	input  wire [3:0]               wb_sel_i,
	input  wire [31:0]              wb_dat_i,
	output logic [31:0]             wb_dat_o,
	output logic                    wb_ack_o,
	input  wire timer_pkg::timer_state_t state_i,
	input  wire                     irq_pending_i,
	output timer_pkg::timer_cfg_t   cfg_o,
	output timer_pkg::timer_cmd_t   cmd_o
);
	import timer_pkg::*;

	timer_cfg_t  cfg_q;
	timer_cmd_t  cmd_q;
	logic        ack_q;
	logic [31:0] dat_q;
	logic [31:0] rd_data;
	logic        req;
	logic        wr;

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
		input logic [31:0] new_val, input logic [3:0] sel);
		logic [31:0] res;
		res = old_val;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				res[8*b +: 8] = new_val[8*b +: 8];
		end
		return res;
	endfunction

	assign req = wb_cyc_i & wb_stb_i & ~ack_q; // Only the first cycle of a request.
	assign wr  = req & wb_we_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_q          <= 1'b0;
			cmd_q          <= '0;
			cfg_q.prescale <= `TIMER_PRE_RESET;
			cfg_q.reload   <= `TIMER_ARE_RESET;
			cfg_q.enable   <= 1'b0;
			cfg_q.count_up <= 1'b1;
			cfg_q.irq_en   <= 1'b0;
		end else begin
			ack_q <= req;
			cmd_q <= '0; // Strobes last one cycle.
			if (wr) begin
				case (wb_adr_i)
					`TIMER_REG_PRE: begin
						cfg_q.prescale <= merge_bytes(cfg_q.prescale, wb_dat_i, wb_sel_i);
						cmd_q.pre_load <= 1'b1; // Restart the divider on the new value.
					end
					`TIMER_REG_ARE: begin
						cfg_q.reload <= merge_bytes(cfg_q.reload, wb_dat_i, wb_sel_i);
					end
					`TIMER_REG_CTRL: begin
						if (wb_sel_i[0]) begin
							cfg_q.enable   <= wb_dat_i[0];
							cfg_q.count_up <= wb_dat_i[1];
							cfg_q.irq_en   <= wb_dat_i[2];
						end
					end
					`TIMER_REG_CMD: begin
						cmd_q.clr_cnt <= wb_dat_i[0];
						cmd_q.clr_evn <= wb_dat_i[1];
						cmd_q.clr_irq <= wb_dat_i[2];
					end
					default: begin
					end
				endcase
			end
		end
	end

	always_comb begin
		case (wb_adr_i)
			`TIMER_REG_PRE:  rd_data = cfg_q.prescale;
			`TIMER_REG_ARE:  rd_data = cfg_q.reload;
			`TIMER_REG_CTRL: rd_data = {29'd0, cfg_q.irq_en, cfg_q.count_up, cfg_q.enable};
			`TIMER_REG_CNT:  rd_data = state_i.count;
			`TIMER_REG_EVN:  rd_data = state_i.events;
			`TIMER_REG_STAT: rd_data = {31'd0, irq_pending_i};
			default:         rd_data = 32'd0; // CMD reads as zero.
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (req)
			dat_q <= rd_data; // Held stable through the ack cycle.
	end

	assign wb_ack_o = ack_q;
	assign wb_dat_o = dat_q;
	assign cfg_o    = cfg_q;
	assign cmd_o    = cmd_q;

	// The master holds its request through the ack cycle.
	a_ack_follows_req: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_ack_o |-> wb_cyc_i && wb_stb_i && $past(wb_cyc_i && wb_stb_i));

endmodule

`default_nettype wire

//--- hw/timer_count_core.sv
`default_nettype none

`include "timer_defines.svh"

module timer_count_core (
	input  wire                          clk_i,
	input  wire                          rst_i,
	input  wire timer_pkg::timer_cfg_t   cfg_i,
	input  wire timer_pkg::timer_cmd_t   cmd_i,
	output timer_pkg::timer_state_t      state_o
);

	logic [31:0] divisor;
	logic [31:0] pre_cnt_q;
	logic [31:0] count_q;
	logic [31:0] events_q;
	logic        evt_q;
	logic        tick;
	logic        hit;

	// All ones in PRE selects the one-second tick.
	assign divisor = (&cfg_i.prescale) ? (`TIMER_CLK_FREQ - 32'd1) : cfg_i.prescale;

	assign tick = cfg_i.enable && (pre_cnt_q == divisor);
	assign hit  = count_q == cfg_i.reload;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pre_cnt_q <= 32'd0;
			count_q   <= 32'd0;
			events_q  <= 32'd0;
			evt_q     <= 1'b0;
		end else begin
			evt_q <= tick && hit;
			if (cfg_i.enable) begin
				if (tick)
					pre_cnt_q <= 32'd0;
				else
					pre_cnt_q <= pre_cnt_q + 32'd1;
			end
			if (tick) begin
				if (hit) begin
					count_q  <= 32'd0; // Terminal value reached.
					events_q <= events_q + 32'd1;
				end else if (cfg_i.count_up) begin
					count_q <= count_q + 32'd1;
				end else begin
					count_q <= count_q - 32'd1; // Wraps through zero to all ones.
				end
			end
			if (cmd_i.pre_load)
				pre_cnt_q <= 32'd0;
			if (cmd_i.clr_cnt) begin
				count_q   <= 32'd0;
				pre_cnt_q <= 32'd0;
			end
			if (cmd_i.clr_evn)
				events_q <= 32'd0;
		end
	end

	assign state_o = '{count: count_q, events: events_q, evt: evt_q};

	// The divisor may shrink under the counter for the one cycle before pre_load resets it.
	a_pre_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
		!cmd_i.pre_load |-> pre_cnt_q <= divisor);

	// The tick behind an event leaves the prescaler and the count at zero.
	a_evt_on_tick: assert property (@(posedge clk_i) disable iff (rst_i)
		evt_q |-> (pre_cnt_q == 32'd0) && (count_q == 32'd0));

endmodule

`default_nettype wire

//--- hw/timer_irq_ctrl.sv
`default_nettype none

module timer_irq_ctrl (
	input  wire  clk_i,
	input  wire  rst_i,
	input  wire  event_i,
	input  wire  irq_en_i,
	input  wire  clr_i,
	input  wire  irq_ack_i,
	output logic irq_o,
	output logic pending_o
);

	logic pending_q;
	logic clear;
	logic set;

	assign clear = clr_i | irq_ack_i;
	assign set   = event_i & irq_en_i; // Events still count while masked.

	always_ff @(posedge clk_i) begin
		if (rst_i)
			pending_q <= 1'b0;
		else if (clear)
			pending_q <= 1'b0; // Clear beats a set in the same cycle.
		else if (set)
			pending_q <= 1'b1;
	end

	assign irq_o     = pending_q;
	assign pending_o = pending_q;

	a_pending_needs_event: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(pending_q) |-> $past(event_i && irq_en_i));

endmodule

`default_nettype wire

//--- hw/timer_top.sv
`default_nettype none

module timer_top (
	input  wire         clk_i,
	input  wire         rst_i,
	input  wire         wb_cyc_i,
	input  wire         wb_stb_i,
	input  wire         wb_we_i,
	input  wire [2:0]   wb_adr_i,
	input  wire [3:0]   wb_sel_i,
	input  wire [31:0]  wb_dat_i,
	output logic [31:0] wb_dat_o,
	output logic        wb_ack_o,
	input  wire         irq_ack_i,
	output logic        irq_o
);
	import timer_pkg::*;

	timer_cfg_t   cfg;
	timer_cmd_t   cmd;
	timer_state_t state;
	logic         irq_pending;

	timer_bus_decode u_decode (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.wb_cyc_i      (wb_cyc_i),
		.wb_stb_i      (wb_stb_i),
		.wb_we_i       (wb_we_i),
		.wb_adr_i      (wb_adr_i),
		.wb_sel_i      (wb_sel_i),
		.wb_dat_i      (wb_dat_i),
		.wb_dat_o      (wb_dat_o),
		.wb_ack_o      (wb_ack_o),
		.state_i       (state),
		.irq_pending_i (irq_pending),
		.cfg_o         (cfg),
		.cmd_o         (cmd)
	);

	timer_count_core u_core (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.cfg_i   (cfg),
		.cmd_i   (cmd),
		.state_o (state)
	);

	timer_irq_ctrl u_irq (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.event_i   (state.evt),
		.irq_en_i  (cfg.irq_en),
		.clr_i     (cmd.clr_irq),
		.irq_ack_i (irq_ack_i),
		.irq_o     (irq_o),
		.pending_o (irq_pending)
	);

endmodule

`default_nettype wire

//--- tb/timer_checker.sv
`default_nettype none

`include "timer_defines.svh"

module timer_checker (
	input  wire        clk_i,
	input  wire        rst_i,
	input  wire        wb_cyc_i,
	input  wire        wb_stb_i,
	input  wire        wb_we_i,
	input  wire [2:0]  wb_adr_i,
	input  wire [3:0]  wb_sel_i,
	input  wire [31:0] wb_dat_i,
	input  wire [31:0] wb_rdat_i,
	input  wire        wb_ack_i,
	input  wire        irq_i,
	input  wire        irq_ack_i,
	output int         err_count_o,
	output int         check_count_o
);

	logic [31:0] pre;
	logic [31:0] are;
	logic [2:0]  ctrl;
	logic [31:0] exp_cnt;
	logic [31:0] exp_evn;
	logic        exp_irq;
	logic        exp_ack;
	logic        req_d1;
	logic        req_d2;
	logic        in_span; // The timer is enabled and the count and pin are in motion.
	logic        irq_prev;
	logic [31:0] cycle;
	logic [31:0] span_start;
	int          errors;
	int          checks;

	// Steps the count once per tick; meeting the reload value wraps to zero and counts an event.
	function automatic void predict_count(input logic [31:0] ticks, input logic [31:0] reload,
		input logic up, input logic [31:0] start, output logic [31:0] cnt,
		output logic [31:0] evts);
		logic [31:0] t;
		cnt = start;
		evts = 32'd0;
		for (t = 32'd0; t < ticks; t = t + 32'd1) begin
			if (cnt == reload) begin
				cnt = 32'd0;
				evts = evts + 32'd1;
			end else if (up) begin
				cnt = cnt + 32'd1;
			end else begin
				cnt = cnt - 32'd1;
			end
		end
	endfunction

	function automatic logic [31:0] apply_byte_mask(input logic [31:0] old_val,
		input logic [31:0] new_val, input logic [3:0] sel);
		logic [31:0] mask;
		mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (old_val & ~mask) | (new_val & mask);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic close_span;
		logic [31:0] div;
		logic [31:0] cnt;
		logic [31:0] evts;
		div = (&pre) ? (`TIMER_CLK_FREQ - 32'd1) : pre;
		predict_count((cycle - span_start) / (div + 32'd1), are, ctrl[1], exp_cnt, cnt, evts);
		exp_cnt = cnt;
		exp_evn = exp_evn + evts;
		if (ctrl[2] && evts != 32'd0)
			exp_irq = 1'b1;
		in_span = 1'b0;
	endtask

	task automatic model_write;
		case (wb_adr_i)
			`TIMER_REG_PRE:  pre = apply_byte_mask(pre, wb_dat_i, wb_sel_i);
			`TIMER_REG_ARE:  are = apply_byte_mask(are, wb_dat_i, wb_sel_i);
			`TIMER_REG_CTRL: begin
				if (wb_sel_i[0]) begin
					if (ctrl[0] && !wb_dat_i[0])
						close_span();
					if (!ctrl[0] && wb_dat_i[0]) begin
						in_span = 1'b1;
						span_start = cycle;
					end
					ctrl = wb_dat_i[2:0];
				end
			end
			`TIMER_REG_CMD: begin
				if (wb_dat_i[0])
					exp_cnt = 32'd0;
				if (wb_dat_i[1])
					exp_evn = 32'd0;
				if (wb_dat_i[2])
					exp_irq = 1'b0;
			end
			default: begin
			end
		endcase
	endtask

	task automatic check_read;
		case (wb_adr_i)
			`TIMER_REG_PRE:  check_value("PRE", wb_rdat_i, pre);
			`TIMER_REG_ARE:  check_value("ARE", wb_rdat_i, are);
			`TIMER_REG_CTRL: check_value("CTRL", wb_rdat_i, {29'd0, ctrl});
			`TIMER_REG_CMD:  check_value("CMD", wb_rdat_i, 32'd0);
			`TIMER_REG_CNT:  check_value("CNT", wb_rdat_i, exp_cnt);
			`TIMER_REG_EVN:  check_value("EVN", wb_rdat_i, exp_evn);
			`TIMER_REG_STAT: check_value("STAT", wb_rdat_i, {31'd0, exp_irq});
			default:         check_value("unmapped", wb_rdat_i, 32'd0);
		endcase
	endtask

	always @(posedge clk_i) begin
		if (rst_i) begin
			pre = `TIMER_PRE_RESET;
			are = `TIMER_ARE_RESET;
			ctrl = 3'b010; // Disabled and counting up with the interrupt masked.
			exp_cnt = 32'd0;
			exp_evn = 32'd0;
			exp_irq = 1'b0;
			req_d1 = 1'b0;
			req_d2 = 1'b0;
			in_span = 1'b0;
			irq_prev = 1'b0;
			cycle = 32'd0;
		end else begin
			cycle = cycle + 32'd1;
			exp_ack = req_d1 && !req_d2; // Ack follows the first cycle of a request.
			check_value("wb_ack_o", {31'd0, wb_ack_i}, {31'd0, exp_ack});
			req_d2 = req_d1;
			req_d1 = wb_cyc_i && wb_stb_i;
			if (irq_ack_i)
				exp_irq = 1'b0;
			if (irq_i && !irq_prev && !ctrl[2]) begin
				errors++;
				$display("Interrupt pin rose while the interrupt enable was clear.");
			end
			irq_prev = irq_i;
			if (wb_ack_i) begin
				if (!in_span)
					check_value("irq_o", {31'd0, irq_i}, {31'd0, exp_irq});
				if (wb_we_i)
					model_write();
				else
					check_read();
			end
		end
	end

	assign err_count_o   = errors;
	assign check_count_o = checks;

endmodule

`default_nettype wire

//--- tb/timer_tb.sv
`default_nettype none

`include "timer_defines.svh"

module timer_tb;

	localparam int RUNS        = 5; // Timed runs of at most MAX_RUN enabled cycles each.
	localparam int MAX_RUN     = 300;
	localparam int XFERS       = 64;
	localparam int XFER_CYCLES = 4;
	localparam int LIMIT       = 2 * (RUNS * MAX_RUN + XFERS * XFER_CYCLES + 10);

	logic        clk;
	logic        rst;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [2:0]  wb_adr;
	logic [3:0]  wb_sel;
	logic [31:0] wb_wdat;
	logic [31:0] wb_rdat;
	logic        wb_ack;
	logic        irq_ack;
	logic        irq;
	logic [31:0] lfsr;
	logic [31:0] div;
	logic [31:0] rel;
	logic [31:0] len;
	int          cycles;
	int          errors;
	int          checks;

	timer_top u_timer_top (
		.clk_i     (clk),
		.rst_i     (rst),
		.wb_cyc_i  (wb_cyc),
		.wb_stb_i  (wb_stb),
		.wb_we_i   (wb_we),
		.wb_adr_i  (wb_adr),
		.wb_sel_i  (wb_sel),
		.wb_dat_i  (wb_wdat),
		.wb_dat_o  (wb_rdat),
		.wb_ack_o  (wb_ack),
		.irq_ack_i (irq_ack),
		.irq_o     (irq)
	);

	timer_checker u_check (
		.clk_i         (clk),
		.rst_i         (rst),
		.wb_cyc_i      (wb_cyc),
		.wb_stb_i      (wb_stb),
		.wb_we_i       (wb_we),
		.wb_adr_i      (wb_adr),
		.wb_sel_i      (wb_sel),
		.wb_dat_i      (wb_wdat),
		.wb_rdat_i     (wb_rdat),
		.wb_ack_i      (wb_ack),
		.irq_i         (irq),
		.irq_ack_i     (irq_ack),
		.err_count_o   (errors),
		.check_count_o (checks)
	);

	// One Galois step per bit taken.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = 32'd0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic pick_params;
		div = 32'd2 + rand_bits(3);
		rel = 32'd3 + rand_bits(5) % 32'd18;
		len = 32'd50 + rand_bits(8) % 32'd251;
	endtask

	task automatic bus_xfer(input logic we, input logic [2:0] adr, input logic [31:0] dat,
		input logic [3:0] sel);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= adr;
		wb_sel <= sel;
		wb_wdat <= dat;
		@(posedge clk);
		while (!wb_ack)
			@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic bus_write(input logic [2:0] adr, input logic [31:0] dat, input logic [3:0] sel);
		bus_xfer(1'b1, adr, dat, sel);
	endtask

	task automatic bus_read(input logic [2:0] adr);
		bus_xfer(1'b0, adr, 32'd0, 4'hf);
	endtask

	task automatic run_timer(input logic [31:0] pre, input logic [31:0] are,
		input logic [2:0] bits, input logic [31:0] cycles_on, input logic until_irq);
		bus_write(`TIMER_REG_PRE, pre, 4'hf);
		bus_write(`TIMER_REG_ARE, are, 4'hf);
		bus_write(`TIMER_REG_CMD, 32'd1, 4'hf); // Count and prescaler start from zero.
		bus_write(`TIMER_REG_CTRL, {29'd0, bits | 3'b001}, 4'hf);
		if (until_irq) begin
			while (!irq)
				@(posedge clk);
		end else begin
			repeat (cycles_on) @(posedge clk);
		end
		bus_write(`TIMER_REG_CTRL, {29'd0, bits & 3'b110}, 4'hf);
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout: no result after %0d cycles.", cycles);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		lfsr = 32'h1834;
		rst <= 1'b1;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		wb_adr <= 3'd0;
		wb_sel <= 4'h0;
		wb_wdat <= 32'd0;
		irq_ack <= 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		for (int a = 0; a < 8; a++)
			bus_read(a[2:0]);
		pick_params();
		run_timer(div, rel, 3'b010, len, 1'b0);
		bus_read(`TIMER_REG_CNT);
		bus_read(`TIMER_REG_EVN);
		pick_params();
		run_timer(div, rel, 3'b000, len, 1'b0);
		bus_read(`TIMER_REG_CNT);
		bus_read(`TIMER_REG_EVN);
		pick_params();
		run_timer(div, 32'd3, 3'b110, 32'd0, 1'b1);
		bus_read(`TIMER_REG_STAT);
		@(posedge clk);
		irq_ack <= 1'b1;
		@(posedge clk);
		irq_ack <= 1'b0;
		bus_read(`TIMER_REG_STAT);
		run_timer(div, 32'd3, 3'b110, 32'd0, 1'b1);
		bus_write(`TIMER_REG_CMD, 32'd4, 4'hf);
		bus_read(`TIMER_REG_STAT);
		run_timer(div, 32'd3, 3'b010, len, 1'b0); // The interrupt is masked and only EVN moves.
		bus_read(`TIMER_REG_EVN);
		bus_read(`TIMER_REG_STAT);
		bus_write(`TIMER_REG_PRE, 32'h1234_5678, 4'b0101);
		bus_read(`TIMER_REG_PRE);
		bus_write(`TIMER_REG_CMD, 32'd2, 4'hf);
		bus_read(`TIMER_REG_EVN);
		bus_write(`TIMER_REG_CNT, 32'hdead_beef, 4'hf);
		bus_read(`TIMER_REG_CNT);
		repeat (4) @(posedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hw
hw/timer_pkg.sv
hw/timer_bus_decode.sv
hw/timer_count_core.sv
hw/timer_irq_ctrl.sv
hw/timer_top.sv
tb/timer_checker.sv
tb/timer_tb.sv

//--- Makefile
SRCS := $(wildcard hw/*.sv hw/*.svh tb/*.sv)

obj_dir/Vtimer_tb: $(SRCS) vlog.f
	verilator --binary --timing --assert --top-module timer_tb -f vlog.f

run: obj_dir/Vtimer_tb
	./obj_dir/Vtimer_tb | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
